// File: flist.f
+incdir+source
source/uart_pkg.sv
source/axi_lite_decode.sv
source/char_line_buffer.sv
source/reg_resp_encode.sv
source/axi_uart.sv
tb/tb_axi_uart.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass message in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_axi_uart -o tb_axi_uart \
  && ./obj_dir/tb_axi_uart | tee /dev/stderr | grep "Regression passed" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: tb/axi_uart_stim.txt
# W addr data strb resp | R addr resp data | L len data, data has the first character in byte 0
# all fields are hex, resp 0 is OKAY and resp 2 is SLVERR
R 004 0 00000000
# "hi" sent one byte at a time
W 000 00000068 1 0
W 000 00000069 1 0
R 004 0 00000002
L 02 00000000000000000000000000006968
W 000 0000000A 1 0
R 004 0 00000000
# sparse strobes keep only the strobed lanes in lane order
W 000 44434241 5 0
W 000 48474645 A 0
W 000 4C4B4A49 F 0
R 004 0 00000008
# the newline code on lane 1 is an ordinary character
W 000 00000A00 2 0
R 004 0 00000009
L 09 000000000000000A4C4B4A4948464341
W 000 0000000A 1 0
# an empty line is still published
L 00 00000000000000000000000000000000
W 000 0000000A 1 0
# sixteen bytes fill the line, the next word is dropped
W 000 33323130 F 0
W 000 37363534 F 0
W 000 42413938 F 0
W 000 46454443 F 0
R 004 0 00000010
W 000 7A797877 F 0
R 004 0 00000110
R 000 0 00000000
L 10 46454443424139383736353433323130
W 000 0000000A 1 0
R 004 0 00000000
# fourteen bytes, then a full word of which two bytes fit
W 000 64636261 F 0
W 000 68676665 F 0
W 000 6C6B6A69 F 0
W 000 00006E6D 3 0
R 004 0 0000000E
W 000 73727170 F 0
R 004 0 00000110
L 10 71706E6D6C6B6A696867666564636261
W 000 0000000A 1 0
R 004 0 00000000
# unmapped addresses and STATUS writes leave the line alone
W 000 00000078 1 0
W 008 00000041 1 2
W 804 0000000A 1 2
W 004 00000041 F 0
R 00C 2 00000000
R 800 2 00000000
R 004 0 00000001
R 000 0 00000000
L 01 00000000000000000000000000000078
W 000 0000000A 1 0
R 004 0 00000000

// File: tb/tb_axi_uart.sv
/* runs tb/axi_uart_stim.txt from the project root, one write and one read at a time;
   gaps, AW/W order and B/R stalls come from a generator seeded with 43 */
`default_nettype none

`include "uart_macros.svh"

module tb_axi_uart;
  import uart_pkg::*;

  // cycles any single wait may take before the run is abandoned
  localparam int unsigned WaitLimit = 200;

  logic      clk_i;
  logic      rst_ni;
  logic      aw_valid_i;
  logic      aw_ready_o;
  addr_t     aw_addr_i;
  logic      w_valid_i;
  logic      w_ready_o;
  data_t     w_data_i;
  strb_t     w_strb_i;
  logic      b_valid_o;
  logic      b_ready_i;
  axi_resp_e b_resp_o;
  logic      ar_valid_i;
  logic      ar_ready_o;
  addr_t     ar_addr_i;
  logic      r_valid_o;
  logic      r_ready_i;
  data_t     r_data_o;
  axi_resp_e r_resp_o;
  logic      line_valid_o;
  len_t      line_len_o;
  line_t     line_data_o;

  // lines announced by the stimulus file, oldest first
  logic [31:0]  exp_len_q[$];
  logic [127:0] exp_data_q[$];

  int unsigned lcg_state = 43;

  axi_uart axi_uart_i (
    .clk_i, .rst_ni,
    .aw_valid_i, .aw_ready_o, .aw_addr_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .b_valid_o, .b_ready_i, .b_resp_o,
    .ar_valid_i, .ar_ready_o, .ar_addr_i,
    .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o,
    .line_valid_o, .line_len_o, .line_data_o
  );

  always #5 clk_i = ~clk_i;

  // linear congruential step, the upper bits are the better ones
  function automatic int unsigned rand_below(input int unsigned bound);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % bound;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic send_aw(input addr_t addr, input int unsigned gap);
    int unsigned n;
    repeat (gap + 1) @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    n = 0;
    @(negedge clk_i);
    while (!aw_ready_o) begin
      n++;
      if (n > WaitLimit) stop_with_failure("timeout: aw_ready_o never rose");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
  endtask

  task automatic send_w(input data_t data, input strb_t strb, input int unsigned gap);
    int unsigned n;
    repeat (gap + 1) @(posedge clk_i);
    w_valid_i <= 1'b1;
    w_data_i  <= data;
    w_strb_i  <= strb;
    n = 0;
    @(negedge clk_i);
    while (!w_ready_o) begin
      n++;
      if (n > WaitLimit) stop_with_failure("timeout: w_ready_o never rose");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    w_valid_i <= 1'b0;
  endtask

  // AW and W start after independent gaps, so either may arrive first
  task automatic do_write(input addr_t addr, input data_t data, input strb_t strb,
                          input logic [1:0] exp_resp);
    int unsigned n;
    int unsigned aw_gap;
    int unsigned w_gap;
    int unsigned stall;
    aw_gap = rand_below(4);
    w_gap  = rand_below(4);
    stall  = rand_below(24);
    fork
      send_aw(addr, aw_gap);
      send_w(data, strb, w_gap);
    join
    n = 0;
    @(negedge clk_i);
    while (!b_valid_o) begin
      n++;
      if (n > WaitLimit) stop_with_failure("timeout: b_valid_o never rose after a write");
      @(negedge clk_i);
    end
    // the response must hold and new writes stay blocked while b_ready is low
    repeat (stall) begin
      @(negedge clk_i);
      compare("b_valid_o", 32'(b_valid_o), 32'd1);
      compare("aw_ready_o", 32'(aw_ready_o), 32'd0);
      compare("w_ready_o", 32'(w_ready_o), 32'd0);
    end
    @(posedge clk_i);
    b_ready_i <= 1'b1;
    @(negedge clk_i);
    compare("b_valid_o", 32'(b_valid_o), 32'd1);
    compare("b_resp_o", 32'(b_resp_o), 32'(exp_resp));
    @(posedge clk_i);
    b_ready_i <= 1'b0;
    @(negedge clk_i);
    // exactly one response per write, and the channels reopen
    compare("b_valid_o", 32'(b_valid_o), 32'd0);
    compare("aw_ready_o", 32'(aw_ready_o), 32'd1);
    compare("w_ready_o", 32'(w_ready_o), 32'd1);
  endtask

  task automatic do_read(input addr_t addr, input logic [1:0] exp_resp, input data_t exp_data);
    int unsigned n;
    int unsigned gap;
    int unsigned stall;
    gap   = rand_below(4);
    stall = rand_below(24);
    repeat (gap + 1) @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    n = 0;
    @(negedge clk_i);
    while (!ar_ready_o) begin
      n++;
      if (n > WaitLimit) stop_with_failure("timeout: ar_ready_o never rose");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!r_valid_o) begin
      n++;
      if (n > WaitLimit) stop_with_failure("timeout: r_valid_o never rose after a read");
      @(negedge clk_i);
    end
    repeat (stall) begin
      @(negedge clk_i);
      compare("r_valid_o", 32'(r_valid_o), 32'd1);
      compare("ar_ready_o", 32'(ar_ready_o), 32'd0);
    end
    @(posedge clk_i);
    r_ready_i <= 1'b1;
    @(negedge clk_i);
    compare("r_valid_o", 32'(r_valid_o), 32'd1);
    compare("r_resp_o", 32'(r_resp_o), 32'(exp_resp));
    compare("r_data_o", r_data_o, exp_data);
    @(posedge clk_i);
    r_ready_i <= 1'b0;
    @(negedge clk_i);
    compare("r_valid_o", 32'(r_valid_o), 32'd0);
  endtask

  // each published line must be the oldest one the stimulus announced
  // bytes at or past the length carry no meaning and are skipped
  task automatic check_line();
    logic [31:0]  exp_len;
    logic [127:0] exp_data;
    if (exp_len_q.size() == 0) stop_with_failure("a line was published that nobody expected");
    exp_len  = exp_len_q.pop_front();
    exp_data = exp_data_q.pop_front();
    // the line appears in the same cycle as the write response of its newline
    compare("b_valid_o", 32'(b_valid_o), 32'd1);
    compare("line_len_o", 32'(line_len_o), exp_len);
    for (int i = 0; i < int'(exp_len) && i < `UART_LINE_MAX; i++) begin
      compare($sformatf("line_data_o[%0d]", i), 32'(line_data_o[i]),
              32'(exp_data[i*8 +: 8]));
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && line_valid_o === 1'b1) begin
      check_line();
    end
  end

  initial begin
    int           fd;
    int           rc;
    string        line_s;
    string        kind;
    logic [127:0] f1;
    logic [127:0] f2;
    logic [127:0] f3;
    logic [127:0] f4;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    // idle state straight out of reset
    compare("aw_ready_o", 32'(aw_ready_o), 32'd1);
    compare("w_ready_o", 32'(w_ready_o), 32'd1);
    compare("ar_ready_o", 32'(ar_ready_o), 32'd1);
    compare("b_valid_o", 32'(b_valid_o), 32'd0);
    compare("r_valid_o", 32'(r_valid_o), 32'd0);
    compare("line_valid_o", 32'(line_valid_o), 32'd0);
    fd = $fopen("tb/axi_uart_stim.txt", "r");
    if (fd == 0) stop_with_failure("could not open tb/axi_uart_stim.txt");
    while (!$feof(fd)) begin
      rc = $fgets(line_s, fd);
      if (rc > 0 && line_s.len() > 1 && line_s.substr(0, 0) != "#") begin
        rc = $sscanf(line_s, "%s %h %h %h %h", kind, f1, f2, f3, f4);
        if (kind == "W") begin
          do_write(f1[11:0], f2[31:0], f3[3:0], f4[1:0]);
        end else if (kind == "R") begin
          do_read(f1[11:0], f2[1:0], f3[31:0]);
        end else if (kind == "L") begin
          // queued ahead of the newline write that publishes it
          exp_len_q.push_back(f1[31:0]);
          exp_data_q.push_back(f2);
        end else begin
          stop_with_failure({"unknown line in the stimulus file: ", line_s});
        end
      end
    end
    $fclose(fd);
    repeat (4) @(negedge clk_i);
    if (exp_len_q.size() != 0) begin
      stop_with_failure("an expected line was never published");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: source/axi_uart.sv
/* AXI4-Lite console with TX at offset 0 and STATUS at offset 4; the line output is a
   single-cycle pulse without back-pressure */
`default_nettype none

module axi_uart (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  uart_pkg::addr_t     aw_addr_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  uart_pkg::data_t     w_data_i,
  input  uart_pkg::strb_t     w_strb_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output uart_pkg::axi_resp_e b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  uart_pkg::addr_t     ar_addr_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output uart_pkg::data_t     r_data_o,
  output uart_pkg::axi_resp_e r_resp_o,
  output logic                line_valid_o,
  output uart_pkg::len_t      line_len_o,
  output uart_pkg::line_t     line_data_o
);
  import uart_pkg::*;

  // register request from the decoder
  logic  wreq;
  data_t wdata;
  strb_t wstrb;
  logic  wsel_tx;
  logic  wsel_err;
  logic  rreq;
  logic  rsel_status;
  logic  rsel_err;

  // state of the line buffer as reported in STATUS
  len_t  status_len;
  logic  status_ovf;

  // response back-pressure into the decoder
  logic  b_busy;
  logic  r_busy;

  axi_lite_decode u_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (aw_valid_i),
    .aw_addr_i     (aw_addr_i),
    .aw_ready_o    (aw_ready_o),
    .w_valid_i     (w_valid_i),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_ready_o     (w_ready_o),
    .ar_valid_i    (ar_valid_i),
    .ar_addr_i     (ar_addr_i),
    .ar_ready_o    (ar_ready_o),
    .b_busy_i      (b_busy),
    .r_busy_i      (r_busy),
    .wreq_o        (wreq),
    .wdata_o       (wdata),
    .wstrb_o       (wstrb),
    .wsel_tx_o     (wsel_tx),
    .wsel_err_o    (wsel_err),
    .rreq_o        (rreq),
    .rsel_status_o (rsel_status),
    .rsel_err_o    (rsel_err)
  );

  char_line_buffer u_line_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wreq_i       (wreq),
    .wdata_i      (wdata),
    .wstrb_i      (wstrb),
    .wsel_tx_i    (wsel_tx),
    .line_valid_o (line_valid_o),
    .line_len_o   (line_len_o),
    .line_data_o  (line_data_o),
    .status_len_o (status_len),
    .status_ovf_o (status_ovf)
  );

  reg_resp_encode u_resp_encode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wreq_i        (wreq),
    .wsel_err_i    (wsel_err),
    .rreq_i        (rreq),
    .rsel_status_i (rsel_status),
    .rsel_err_i    (rsel_err),
    .status_len_i  (status_len),
    .status_ovf_i  (status_ovf),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .b_resp_o      (b_resp_o),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_data_o      (r_data_o),
    .r_resp_o      (r_resp_o),
    .b_busy_o      (b_busy),
    .r_busy_o      (r_busy)
  );

endmodule

`default_nettype wire

// File: source/reg_resp_encode.sv
/* one response per channel is held at a time; the decoder must not issue a new request
   while the matching busy output is high */
`default_nettype none

`include "uart_macros.svh"

module reg_resp_encode (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wreq_i,
  input  logic                wsel_err_i,
  input  logic                rreq_i,
  input  logic                rsel_status_i,
  input  logic                rsel_err_i,
  input  uart_pkg::len_t      status_len_i,
  input  logic                status_ovf_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output uart_pkg::axi_resp_e b_resp_o,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output uart_pkg::data_t     r_data_o,
  output uart_pkg::axi_resp_e r_resp_o,
  output logic                b_busy_o,
  output logic                r_busy_o
);
  import uart_pkg::*;

  // read word of the STATUS register, length in the low bits and overflow above it
  data_t status_word;

  always_comb begin
    status_word                       = '0;
    status_word[`UART_LEN_W-1:0]      = status_len_i;
    status_word[`UART_STATUS_OVF_BIT] = status_ovf_i;
  end

  // valid flags rise on a request and fall on the accepting handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_o <= 1'b0;
      r_valid_o <= 1'b0;
    end else begin
      if (wreq_i) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      if (rreq_i) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
    end
  end

  // response payloads are loaded with the request and then held until accepted
  always_ff @(posedge clk_i) begin
    if (wreq_i) begin
      b_resp_o <= wsel_err_i ? SLVERR : OKAY;
    end
    if (rreq_i) begin
      r_resp_o <= rsel_err_i ? SLVERR : OKAY;
      // TX and unmapped addresses read as zero
      r_data_o <= rsel_status_i ? status_word : '0;
    end
  end

  // a response waiting on its channel blocks new requests in the decoder
  assign b_busy_o = b_valid_o;
  assign r_busy_o = r_valid_o;

endmodule

`default_nettype wire

// File: source/char_line_buffer.sv
/* a newline write is the full data word equal to the newline code with lane 0 alone strobed;
   bytes past the line capacity are dropped and only raise the overflow flag */
`default_nettype none

`include "uart_macros.svh"

module char_line_buffer (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            wreq_i,
  input  uart_pkg::data_t wdata_i,
  input  uart_pkg::strb_t wstrb_i,
  input  logic            wsel_tx_i,
  output logic            line_valid_o,
  output uart_pkg::len_t  line_len_o,
  output uart_pkg::line_t line_data_o,
  output uart_pkg::len_t  status_len_o,
  output logic            status_ovf_o
);
  import uart_pkg::*;

  localparam int unsigned IdxW = $clog2(`UART_LINE_MAX);

  // collected characters, their count and the overflow flag
  line_t line_q;
  len_t  len_q;
  logic  ovf_q;

  // state after appending the strobed lanes of the current write
  line_t line_app;
  len_t  len_app;
  logic  ovf_app;

  logic  tx_wr;
  logic  newline;

  assign tx_wr = wreq_i && wsel_tx_i;

  // only the exact newline word on lane 0 ends a line, anything else is appended
  assign newline = (wdata_i == data_t'(`UART_NEWLINE)) && (wstrb_i == strb_t'(1));

  // pack the strobed lanes behind the current length in ascending lane order
  always_comb begin
    line_app = line_q;
    len_app  = len_q;
    ovf_app  = ovf_q;
    for (int i = 0; i < `UART_STRB_W; i++) begin
      if (wstrb_i[i]) begin
        if (len_app < len_t'(`UART_LINE_MAX)) begin
          line_app[len_app[IdxW-1:0]] = wdata_i[i*8 +: 8];
          len_app = len_app + len_t'(1);
        end else begin
          // no room left for this byte
          ovf_app = 1'b1;
        end
      end
    end
  end

  // length and overflow are control state and reset to an empty line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q        <= '0;
      ovf_q        <= 1'b0;
      line_valid_o <= 1'b0;
    end else begin
      line_valid_o <= tx_wr && newline;
      if (tx_wr) begin
        if (newline) begin
          len_q <= '0;
          ovf_q <= 1'b0;
        end else begin
          len_q <= len_app;
          ovf_q <= ovf_app;
        end
      end
    end
  end

  // the byte array and the published copy carry data only
  always_ff @(posedge clk_i) begin
    if (tx_wr) begin
      if (newline) begin
        // hand the finished line to the output and start the next one empty
        line_data_o <= line_q;
        line_len_o  <= len_q;
        line_q      <= '0;
      end else begin
        line_q <= line_app;
      end
    end
  end

  assign status_len_o = len_q;
  assign status_ovf_o = ovf_q;

endmodule

`default_nettype wire

// File: source/axi_lite_decode.sv
/* one write and one read in flight at most; AW and W are captured separately and may
   arrive in any order, bursts, IDs and protection bits are not supported */
`default_nettype none

`include "uart_macros.svh"

module axi_lite_decode (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            aw_valid_i,
  input  uart_pkg::addr_t aw_addr_i,
  output logic            aw_ready_o,
  input  logic            w_valid_i,
  input  uart_pkg::data_t w_data_i,
  input  uart_pkg::strb_t w_strb_i,
  output logic            w_ready_o,
  input  logic            ar_valid_i,
  input  uart_pkg::addr_t ar_addr_i,
  output logic            ar_ready_o,
  input  logic            b_busy_i,
  input  logic            r_busy_i,
  output logic            wreq_o,
  output uart_pkg::data_t wdata_o,
  output uart_pkg::strb_t wstrb_o,
  output logic            wsel_tx_o,
  output logic            wsel_err_o,
  output logic            rreq_o,
  output logic            rsel_status_o,
  output logic            rsel_err_o
);
  import uart_pkg::*;

  // captured write address and write data, each with its own full flag
  addr_t aw_addr_q;
  logic  aw_full_q;
  data_t w_data_q;
  strb_t w_strb_q;
  logic  w_full_q;

  // captured read address
  addr_t ar_addr_q;
  logic  ar_full_q;

  logic  aw_hs;
  logic  w_hs;
  logic  ar_hs;

  logic  wsel_status;
  logic  rsel_tx;

  // compares word addresses, the two byte-offset bits are ignored
  function automatic logic word_hit(input addr_t addr, input addr_t offs);
    return addr[`UART_ADDR_W-1:2] == offs[`UART_ADDR_W-1:2];
  endfunction

  // a channel is ready only while its capture is empty and no response is still waiting
  assign aw_ready_o = !aw_full_q && !b_busy_i;
  assign w_ready_o  = !w_full_q && !b_busy_i;
  assign ar_ready_o = !ar_full_q && !r_busy_i;

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign ar_hs = ar_valid_i && ar_ready_o;

  // both halves of the write are present, so the request lasts exactly this cycle
  // because the captures empty on the edge that ends it
  assign wreq_o  = aw_full_q && w_full_q;
  assign wdata_o = w_data_q;
  assign wstrb_o = w_strb_q;

  // the read request follows the AR capture by one cycle
  assign rreq_o = ar_full_q;

  // address decode of the captured addresses
  assign wsel_tx_o   = word_hit(aw_addr_q, addr_t'(`UART_TX_OFFS));
  assign wsel_status = word_hit(aw_addr_q, addr_t'(`UART_STATUS_OFFS));
  assign wsel_err_o  = !wsel_tx_o && !wsel_status;

  assign rsel_tx       = word_hit(ar_addr_q, addr_t'(`UART_TX_OFFS));
  assign rsel_status_o = word_hit(ar_addr_q, addr_t'(`UART_STATUS_OFFS));
  assign rsel_err_o    = !rsel_tx && !rsel_status_o;

  // full flags
  // a handshake cannot coincide with the request of its own channel, ready is low then
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      ar_full_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_full_q <= 1'b1;
      end else if (wreq_o) begin
        aw_full_q <= 1'b0;
      end
      if (w_hs) begin
        w_full_q <= 1'b1;
      end else if (wreq_o) begin
        w_full_q <= 1'b0;
      end
      if (ar_hs) begin
        ar_full_q <= 1'b1;
      end else if (rreq_o) begin
        ar_full_q <= 1'b0;
      end
    end
  end

  // payload captures, only meaningful while the matching full flag is set
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= aw_addr_i;
    end
    if (w_hs) begin
      w_data_q <= w_data_i;
      w_strb_q <= w_strb_i;
    end
    if (ar_hs) begin
      ar_addr_q <= ar_addr_i;
    end
  end

endmodule

`default_nettype wire

// File: source/uart_pkg.sv
/* shared types of the console; widths come from the macro header,
   so change them there and not here */
`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

  // byte address as seen on the AXI-Lite AW and AR channels
  typedef logic [`UART_ADDR_W-1:0] addr_t;

  // one register word as carried on W and R
  typedef logic [`UART_DATA_W-1:0] data_t;

  // byte enables of a write, lane 0 is data bits 7:0
  typedef logic [`UART_STRB_W-1:0] strb_t;

  // number of characters held in the line, 0 up to UART_LINE_MAX
  typedef logic [`UART_LEN_W-1:0] len_t;

  // the collected characters
  // entry 0 holds the first byte received, entries at or past the length are zero
  typedef logic [`UART_LINE_MAX-1:0][7:0] line_t;

  // AXI response codes used by this subordinate
  // EXOKAY and DECERR are never produced
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

// File: source/uart_macros.svh
/* widths, register map and line limits of the console; the address must stay word aligned
   and the line capacity must be a power of two no larger than 31 */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// AXI-Lite address and data widths, one strobe bit per data byte
`define UART_ADDR_W 12
`define UART_DATA_W 32
`define UART_STRB_W (`UART_DATA_W / 8)

// bytes held before the overflow flag is raised
`define UART_LINE_MAX 16
// length field, wide enough to count 0 up to a full line
`define UART_LEN_W 5
`define UART_NEWLINE 8'h0A

// byte offsets of the two registers and the bit of the overflow flag in STATUS
`define UART_TX_OFFS 12'h000
`define UART_STATUS_OFFS 12'h004
`define UART_STATUS_OVF_BIT 8

`endif
